//--- Makefile
# Verilator simulation of the Modbus RTU slave
# Pass or fail comes from the pass message in the log

VERILATOR ?= verilator
TOP       ?= tb_modbus_rtu_slave
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/modbus_pkg.sv
// ============================
// Shared constants and types for the Modbus RTU slave
// Register image is REG_WORDS words and must stay a power of two
// so that address offsets wrap by truncation
// ============================
`default_nettype none

package modbus_pkg;

  // ============================
  // Sizes
  // ============================
  localparam int REG_WORDS    = 64;
  localparam int RX_BUF_DEPTH = 256;
  localparam int FIFO_DEPTH   = 256;

  // ============================
  // CRC-16 (Modbus, reflected)
  // ============================
  localparam logic [15:0] CRC_INIT = 16'hFFFF;
  localparam logic [15:0] CRC_POLY = 16'hA001;

  // Supported function codes
  localparam logic [7:0] FC_READ_HOLDING = 8'h03;
  localparam logic [7:0] FC_WRITE_SINGLE = 8'h06;
  localparam logic [7:0] FC_WRITE_MULTI  = 8'h10;

  typedef logic [$clog2(REG_WORDS)-1:0] reg_addr_t;
  typedef logic [7:0] rx_idx_t;

  // Decoded request header, bytes 0 to 6 of the frame
  typedef struct packed {
    logic [7:0]  dev_addr;
    logic [7:0]  func;
    logic [15:0] addr;
    logic [15:0] qty_or_val;   // qty for 03 and 10, value for 06
    logic [7:0]  byte_count;
  } modbus_req_t;

  // One response payload byte, last marks the end of the response
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } resp_byte_t;

  // Fold one byte into the running CRC, LSB first
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

//--- logic/modbus_rtu_slave.sv
// ============================
// Modbus RTU holding-register slave, top level
// Device address is echoed and never filtered
// stat_crc_err is sticky until reset
// ============================
`timescale 1ns/1ps
`default_nettype none

module modbus_rtu_slave (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] map_base,
  input  logic [7:0]  rx_b,
  input  logic        rx_b_v,
  input  logic        frame_start,
  input  logic        frame_end,
  output logic [7:0]  tx_b,
  output logic        tx_b_v,
  input  logic        tx_b_rdy,
  output logic        stat_crc_err
);
  import modbus_pkg::*;

  modbus_req_t req;
  logic        req_valid;
  logic        busy;
  rx_idx_t     rd_idx;
  logic [7:0]  rd_data;
  logic        push;
  resp_byte_t  push_data;
  logic        full;
  logic        pop;
  resp_byte_t  pop_data;
  logic        empty;

  rtu_frame_rx u_rx (
    .clk(clk), .rst(rst), .rx_b(rx_b), .rx_b_v(rx_b_v),
    .frame_start(frame_start), .frame_end(frame_end), .busy(busy),
    .rd_idx(rd_idx), .rd_data(rd_data), .req(req), .req_valid(req_valid),
    .stat_crc_err(stat_crc_err)
  );

  slave_engine u_engine (
    .clk(clk), .rst(rst), .map_base(map_base), .req(req), .req_valid(req_valid),
    .busy(busy), .rd_idx(rd_idx), .rd_data(rd_data), .push(push),
    .push_data(push_data), .full(full)
  );

  resp_fifo u_fifo (
    .clk(clk), .rst(rst), .push(push), .push_data(push_data), .full(full),
    .pop(pop), .pop_data(pop_data), .empty(empty)
  );

  rtu_tx_framer u_tx (
    .clk(clk), .rst(rst), .pop_data(pop_data), .empty(empty), .pop(pop),
    .tx_b(tx_b), .tx_b_v(tx_b_v), .tx_b_rdy(tx_b_rdy)
  );

endmodule

`default_nettype wire

//--- logic/resp_fifo.sv
// ============================
// First-word-fall-through response FIFO
// Push while full and pop while empty are ignored
// ============================
`timescale 1ns/1ps
`default_nettype none

module resp_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  modbus_pkg::resp_byte_t push_data,
  output logic                   full,
  input  logic                   pop,
  output modbus_pkg::resp_byte_t pop_data,
  output logic                   empty
);
  import modbus_pkg::*;

  resp_byte_t                     mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
  logic [$clog2(FIFO_DEPTH):0]    count;
  logic                           do_push;
  logic                           do_pop;

  assign full     = (count == FIFO_DEPTH);
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  // Head entry is visible without a read cycle
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/rtu_frame_rx.sv
// ============================
// Collects one RTU frame between frame_start and frame_end
// Bytes past RX_BUF_DEPTH are dropped and left out of the CRC
// frame_start is ignored while the engine is busy
// ============================
`timescale 1ns/1ps
`default_nettype none

module rtu_frame_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [7:0]              rx_b,
  input  logic                    rx_b_v,
  input  logic                    frame_start,
  input  logic                    frame_end,
  input  logic                    busy,
  input  modbus_pkg::rx_idx_t     rd_idx,
  output logic [7:0]              rd_data,
  output modbus_pkg::modbus_req_t req,
  output logic                    req_valid,
  output logic                    stat_crc_err
);
  import modbus_pkg::*;

  logic [7:0]  rx_mem [RX_BUF_DEPTH];
  logic [7:0]  hdr [7];
  logic [8:0]  count;
  logic [15:0] crc;
  logic        in_frame;
  logic        end_q;

  logic        start_ok;
  logic        take;
  logic [8:0]  wr_idx;
  logic [15:0] crc_base;
  logic        frame_ok;

  assign start_ok = frame_start && !busy;
  // A byte on the start cycle is the first byte of the new frame
  assign wr_idx   = start_ok ? 9'd0 : count;
  assign crc_base = start_ok ? CRC_INIT : crc;
  assign take     = rx_b_v && (in_frame || start_ok) && (wr_idx < RX_BUF_DEPTH);
  // Residue over data plus CRC bytes is zero for a good frame
  assign frame_ok = end_q && (count >= 9'd4) && (crc == 16'h0000);

  // ============================
  // Frame control
  // ============================
  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame     <= 1'b0;
      end_q        <= 1'b0;
      count        <= '0;
      crc          <= CRC_INIT;
      req_valid    <= 1'b0;
      stat_crc_err <= 1'b0;
    end else begin
      end_q     <= frame_end && (in_frame || start_ok);
      req_valid <= frame_ok;
      if (start_ok) begin
        in_frame <= 1'b1;
        count    <= '0;
        crc      <= CRC_INIT;
      end
      if (take) begin
        count <= wr_idx + 9'd1;
        crc   <= crc16_step(crc_base, rx_b);
      end
      if (frame_end) begin
        in_frame <= 1'b0;
      end
      // Short frames fall through with no pulse at all
      if (end_q && (count >= 9'd4) && (crc != 16'h0000)) begin
        stat_crc_err <= 1'b1;
      end
    end
  end

  // Frame storage, header shadow and decoded request
  always_ff @(posedge clk) begin
    if (take) begin
      rx_mem[wr_idx[7:0]] <= rx_b;
      if (wr_idx < 9'd7) begin
        hdr[wr_idx[2:0]] <= rx_b;
      end
    end
    rd_data <= rx_mem[rd_idx];
    if (frame_ok) begin
      req.dev_addr   <= hdr[0];
      req.func       <= hdr[1];
      req.addr       <= {hdr[2], hdr[3]};
      req.qty_or_val <= {hdr[4], hdr[5]};
      req.byte_count <= hdr[6];
    end
  end

endmodule

`default_nettype wire

//--- logic/rtu_tx_framer.sv
// ============================
// Sends response bytes when tx_b_rdy is high, then CRC low and high
// A byte leaves in the cycle after tx_b_rdy was sampled
// ============================
`timescale 1ns/1ps
`default_nettype none

module rtu_tx_framer (
  input  logic                   clk,
  input  logic                   rst,
  input  modbus_pkg::resp_byte_t pop_data,
  input  logic                   empty,
  output logic                   pop,
  output logic [7:0]             tx_b,
  output logic                   tx_b_v,
  input  logic                   tx_b_rdy
);
  import modbus_pkg::*;

  typedef enum logic [1:0] {S_DATA, S_CRC_LO, S_CRC_HI} state_t;

  state_t      state;
  logic [15:0] crc;

  assign pop = (state == S_DATA) && tx_b_rdy && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= S_DATA;
      crc    <= CRC_INIT;
      tx_b   <= '0;
      tx_b_v <= 1'b0;
    end else begin
      tx_b_v <= 1'b0;
      case (state)
        S_DATA: begin
          if (pop) begin
            tx_b   <= pop_data.data;
            tx_b_v <= 1'b1;
            crc    <= crc16_step(crc, pop_data.data);
            if (pop_data.last) state <= S_CRC_LO;
          end
        end
        S_CRC_LO: begin
          if (tx_b_rdy) begin
            tx_b   <= crc[7:0];
            tx_b_v <= 1'b1;
            state  <= S_CRC_HI;
          end
        end
        S_CRC_HI: begin
          if (tx_b_rdy) begin
            tx_b   <= crc[15:8];
            tx_b_v <= 1'b1;
            crc    <= CRC_INIT;   // ready for the next response
            state  <= S_DATA;
          end
        end
        default: state <= S_DATA;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/slave_engine.sv
// ============================
// Executes 03, 06 and 10 against the holding-register image
// Offsets wrap modulo REG_WORDS, quantities are not range checked
// Function 10 data must fit in the receive buffer
// ============================
`timescale 1ns/1ps
`default_nettype none

module slave_engine (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [15:0]             map_base,
  input  modbus_pkg::modbus_req_t req,
  input  logic                    req_valid,
  output logic                    busy,
  output modbus_pkg::rx_idx_t     rd_idx,
  input  logic [7:0]              rd_data,
  output logic                    push,
  output modbus_pkg::resp_byte_t  push_data,
  input  logic                    full
);
  import modbus_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_WLOAD, S_HDR, S_RDREG} state_t;

  state_t      state;
  logic [15:0] regs [REG_WORDS];
  reg_addr_t   base_off;
  reg_addr_t   woff;
  logic [16:0] cnt;
  logic        rd_v;
  logic [7:0]  hi_q;

  reg_addr_t   req_off;
  logic        is_read;
  logic [2:0]  hdr_len;
  logic [16:0] nbytes;
  logic [15:0] rd_word;
  logic [7:0]  hdr_byte;

  // req stays steady while busy, so it is used directly
  assign req_off = reg_addr_t'(req.addr - map_base);
  assign is_read = (req.func == FC_READ_HOLDING);
  assign hdr_len = is_read ? 3'd3 : 3'd6;
  assign nbytes  = {req.qty_or_val, 1'b0};
  assign busy    = req_valid || (state != S_IDLE);
  // Data words of function 10 start at request byte 7
  assign rd_idx  = rx_idx_t'(cnt + 17'd7);
  assign rd_word = regs[reg_addr_t'(base_off + reg_addr_t'(cnt[16:1]))];

  always_comb begin
    case (cnt[2:0])
      3'd0:    hdr_byte = req.dev_addr;
      3'd1:    hdr_byte = req.func;
      3'd2:    hdr_byte = is_read ? nbytes[7:0] : req.addr[15:8];
      3'd3:    hdr_byte = req.addr[7:0];
      3'd4:    hdr_byte = req.qty_or_val[15:8];
      default: hdr_byte = req.qty_or_val[7:0];
    endcase
  end

  // ============================
  // Response byte source
  // ============================
  always_comb begin
    push           = 1'b0;
    push_data.data = hdr_byte;
    push_data.last = 1'b0;
    if (state == S_HDR) begin
      push           = !full;
      push_data.last = (cnt[2:0] == hdr_len - 3'd1) && !(is_read && nbytes != '0);
    end else if (state == S_RDREG) begin
      push           = !full;
      push_data.data = cnt[0] ? rd_word[7:0] : rd_word[15:8];
      push_data.last = (cnt == nbytes - 17'd1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      cnt      <= '0;
      rd_v     <= 1'b0;
      base_off <= '0;
      woff     <= '0;
      hi_q     <= '0;
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        S_IDLE: begin
          cnt      <= '0;
          rd_v     <= 1'b0;
          base_off <= req_off;
          woff     <= req_off;
          if (req_valid) begin
            case (req.func)
              FC_READ_HOLDING: state <= S_HDR;
              FC_WRITE_SINGLE: begin
                regs[req_off] <= req.qty_or_val;
                state         <= S_HDR;
              end
              FC_WRITE_MULTI:  state <= S_WLOAD;
              default:         state <= S_IDLE;
            endcase
          end
        end
        // Read data issued at cnt arrives one cycle later
        S_WLOAD: begin
          if (cnt != nbytes) begin
            cnt <= cnt + 17'd1;
          end
          rd_v <= (cnt != nbytes);
          if (rd_v) begin
            if (cnt[0]) begin
              hi_q <= rd_data;
            end else begin
              regs[woff] <= {hi_q, rd_data};
              woff       <= woff + reg_addr_t'(1);
            end
          end else if (cnt == nbytes) begin
            cnt   <= '0;
            state <= S_HDR;
          end
        end
        S_HDR: begin
          if (!full) begin
            if (cnt[2:0] == hdr_len - 3'd1) begin
              cnt   <= '0;
              state <= (is_read && nbytes != '0) ? S_RDREG : S_IDLE;
            end else begin
              cnt <= cnt + 17'd1;
            end
          end
        end
        S_RDREG: begin
          if (!full) begin
            cnt <= cnt + 17'd1;
            if (cnt == nbytes - 17'd1) begin
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src.f
logic/modbus_pkg.sv
logic/rtu_frame_rx.sv
logic/slave_engine.sv
logic/resp_fifo.sv
logic/rtu_tx_framer.sv
logic/modbus_rtu_slave.sv
test/tb_modbus_rtu_slave_chk.sv
test/tb_modbus_rtu_slave.sv

//--- test/tb_modbus_rtu_slave.sv
// ==============================
// Testbench for the Modbus RTU slave
// map_base is held at 0 and frames are sent back to back
// tx_b_rdy is random only in the last test
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_modbus_rtu_slave;
  import modbus_pkg::*;

  localparam int RESET_CYCLES    = 10;
  localparam int NUM_FRAMES      = 12;
  localparam int MAX_FRAME_BYTES = 25;
  localparam int MAX_RESP_BYTES  = 37;
  localparam int CYCLE_LIMIT     =
    NUM_FRAMES * (MAX_FRAME_BYTES + 2 * MAX_RESP_BYTES) * 8 + RESET_CYCLES;
  localparam int RESP_TIMEOUT    = 1000;
  localparam int QUIET_CYCLES    = 40;
  localparam logic [7:0]  DEV    = 8'h11;
  localparam logic [15:0] SEED   = 16'd40586;

  logic        clk;
  logic        rst;
  logic [15:0] map_base;
  logic [7:0]  rx_b;
  logic        rx_b_v;
  logic        frame_start;
  logic        frame_end;
  logic [7:0]  tx_b;
  logic        tx_b_v;
  logic        tx_b_rdy;
  logic        stat_crc_err;

  logic [7:0]  frame_q [$];
  logic [7:0]  exp_q [$];
  logic [7:0]  got_q [$];
  logic [15:0] ref_regs [REG_WORDS];
  logic [15:0] wr_words [16];
  logic [15:0] lfsr_state;
  logic        rdy_pattern [256];
  logic [7:0]  rdy_idx;
  logic        rdy_random;
  int          cycle_count;
  int          error_count;
  int          check_count;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  modbus_rtu_slave DUT (
    .clk(clk), .rst(rst), .map_base(map_base), .rx_b(rx_b), .rx_b_v(rx_b_v),
    .frame_start(frame_start), .frame_end(frame_end), .tx_b(tx_b), .tx_b_v(tx_b_v),
    .tx_b_rdy(tx_b_rdy), .stat_crc_err(stat_crc_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Collector for every transmitted byte
  always @(posedge clk) begin
    if (!rst && tx_b_v) begin
      got_q.push_back(tx_b);
    end
  end

  // Ready is held high unless the random pattern is switched on
  always @(posedge clk) begin
    if (rdy_random) begin
      tx_b_rdy <= rdy_pattern[rdy_idx];
      rdy_idx  <= rdy_idx + 8'd1;
    end else begin
      tx_b_rdy <= 1'b1;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles, the tests did not finish in time", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

  // ==============================
  // Random numbers
  // ==============================
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] lfsr_take(input int nbits);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      r = {r[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  // ==============================
  // Reference model
  // ==============================
  function automatic logic [15:0] crc_over_frame();
    logic [15:0] crc;
    crc = CRC_INIT;
    foreach (frame_q[i]) begin
      crc = crc16_step(crc, frame_q[i]);
    end
    return crc;
  endfunction

  // Builds the expected response with CRC and updates the model image on writes
  function automatic void ref_response(input logic [7:0] dev, input logic [7:0] func,
                                       input logic [15:0] addr, input logic [15:0] qv);
    logic [15:0] diff;
    logic [15:0] word;
    logic [15:0] nbytes;
    logic [15:0] crc;
    int          off;
    exp_q.delete();
    diff   = addr - map_base;
    off    = int'(diff) % REG_WORDS;
    nbytes = qv << 1;
    case (func)
      FC_READ_HOLDING: begin
        exp_q.push_back(dev);
        exp_q.push_back(func);
        exp_q.push_back(nbytes[7:0]);
        for (int i = 0; i < int'(qv); i++) begin
          word = ref_regs[(off + i) % REG_WORDS];
          exp_q.push_back(word[15:8]);
          exp_q.push_back(word[7:0]);
        end
      end
      FC_WRITE_SINGLE: ref_regs[off] = qv;
      FC_WRITE_MULTI: begin
        for (int i = 0; i < int'(qv); i++) begin
          ref_regs[(off + i) % REG_WORDS] = wr_words[i];
        end
      end
      default: ;
    endcase
    // Both write functions echo address and value or qty
    if (func == FC_WRITE_SINGLE || func == FC_WRITE_MULTI) begin
      exp_q.push_back(dev);
      exp_q.push_back(func);
      exp_q.push_back(addr[15:8]);
      exp_q.push_back(addr[7:0]);
      exp_q.push_back(qv[15:8]);
      exp_q.push_back(qv[7:0]);
    end
    if (exp_q.size() != 0) begin
      crc = CRC_INIT;
      foreach (exp_q[i]) begin
        crc = crc16_step(crc, exp_q[i]);
      end
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
  endfunction

  // ==============================
  // Checks and stimulus
  // ==============================
  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("FAIL at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic start_request(input logic [7:0] func, input logic [15:0] addr,
                               input logic [15:0] qv);
    frame_q.delete();
    frame_q.push_back(DEV);
    frame_q.push_back(func);
    frame_q.push_back(addr[15:8]);
    frame_q.push_back(addr[7:0]);
    frame_q.push_back(qv[15:8]);
    frame_q.push_back(qv[7:0]);
  endtask

  // Appends the CRC and sends the frame with start on the first byte and end on the last
  task automatic send_frame(input bit corrupt);
    logic [15:0] crc;
    int          last;
    got_q.delete();
    crc = crc_over_frame();
    if (corrupt) begin
      crc = crc ^ 16'h0001;
    end
    frame_q.push_back(crc[7:0]);
    frame_q.push_back(crc[15:8]);
    last = frame_q.size() - 1;
    for (int i = 0; i <= last; i++) begin
      @(posedge clk);
      rx_b        <= frame_q[i];
      rx_b_v      <= 1'b1;
      frame_start <= (i == 0);
      frame_end   <= (i == last);
    end
    @(posedge clk);
    rx_b_v      <= 1'b0;
    frame_start <= 1'b0;
    frame_end   <= 1'b0;
  endtask

  task automatic expect_response(input string what);
    int waited;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < RESP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (got_q.size() < exp_q.size()) begin
      $display("Response to %s never arrived, %0d of %0d bytes after %0d cycles",
               what, got_q.size(), exp_q.size(), RESP_TIMEOUT);
      error_count++;
      test_errors++;
    end else begin
      // A few more cycles to catch extra bytes
      repeat (8) @(negedge clk);
      check_equal(got_q.size(), exp_q.size(), {what, " length"});
      for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
        check_equal(32'(got_q[i]), 32'(exp_q[i]), $sformatf("%s byte %0d", what, i));
      end
    end
  endtask

  task automatic expect_silence(input string what);
    repeat (QUIET_CYCLES) @(negedge clk);
    check_equal(got_q.size(), 0, {what, " gave bytes"});
  endtask

  task automatic finish_test(input int num, input string name);
    if (test_errors == 0) begin
      $display("Test %0d %s: passed", num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    logic [15:0] addr;
    logic [15:0] val;
    logic [15:0] bit_val;
    rst          = 1'b1;
    map_base     = 16'h0000;
    rx_b         = 8'h00;
    rx_b_v       = 1'b0;
    frame_start  = 1'b0;
    frame_end    = 1'b0;
    tx_b_rdy     = 1'b1;
    rdy_random   = 1'b0;
    rdy_idx      = 8'd0;
    lfsr_state   = SEED;
    error_count  = 0;
    check_count  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < REG_WORDS; i++) begin
      ref_regs[i] = 16'h0000;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // Known Modbus vector 01 03 00 00 00 01 ends in 84 0A
    start_request(FC_READ_HOLDING, 16'd0, 16'd1);
    frame_q[0] = 8'h01;
    check_equal(crc_over_frame(), 16'h0A84, "CRC reference vector");
    start_request(FC_READ_HOLDING, 16'd0, 16'd4);
    ref_response(DEV, FC_READ_HOLDING, 16'd0, 16'd4);
    send_frame(1'b0);
    expect_response("read after reset");
    finish_test(1, "read after reset");

    for (int n = 0; n < 3; n++) begin
      addr = lfsr_take(6);
      val  = lfsr_take(16);
      start_request(FC_WRITE_SINGLE, addr, val);
      ref_response(DEV, FC_WRITE_SINGLE, addr, val);
      send_frame(1'b0);
      expect_response("write single");
      start_request(FC_READ_HOLDING, addr, 16'd1);
      ref_response(DEV, FC_READ_HOLDING, addr, 16'd1);
      send_frame(1'b0);
      expect_response("read back single");
    end
    finish_test(2, "write single register");

    start_request(FC_WRITE_MULTI, 16'd20, 16'd8);
    frame_q.push_back(8'd16);
    for (int i = 0; i < 8; i++) begin
      wr_words[i] = lfsr_take(16);
      frame_q.push_back(wr_words[i][15:8]);
      frame_q.push_back(wr_words[i][7:0]);
    end
    ref_response(DEV, FC_WRITE_MULTI, 16'd20, 16'd8);
    send_frame(1'b0);
    expect_response("write multiple");
    start_request(FC_READ_HOLDING, 16'd20, 16'd8);
    ref_response(DEV, FC_READ_HOLDING, 16'd20, 16'd8);
    send_frame(1'b0);
    expect_response("read back multiple");
    finish_test(3, "write multiple registers");

    // Function 07 goes first so that a wrongly set flag shows up
    check_equal(stat_crc_err, 1'b0, "CRC flag before dropped frames");
    start_request(8'h07, 16'd0, 16'd1);
    send_frame(1'b0);
    expect_silence("function 07 frame");
    check_equal(stat_crc_err, 1'b0, "CRC flag after function 07");
    start_request(FC_READ_HOLDING, 16'd0, 16'd2);
    send_frame(1'b1);
    expect_silence("corrupted CRC frame");
    check_equal(stat_crc_err, 1'b1, "CRC flag after bad frame");
    finish_test(4, "dropped frames");

    for (int i = 0; i < 256; i++) begin
      bit_val        = lfsr_take(1);
      rdy_pattern[i] = bit_val[0];
    end
    @(posedge clk);
    rdy_random <= 1'b1;
    start_request(FC_READ_HOLDING, 16'd16, 16'd16);
    ref_response(DEV, FC_READ_HOLDING, 16'd16, 16'd16);
    send_frame(1'b0);
    expect_response("read under random ready");
    rdy_random <= 1'b0;
    finish_test(5, "random ready");

    if (DUT.u_chk.assert_fails != 0) begin
      $display("Bound assertions failed %0d times", DUT.u_chk.assert_fails);
      error_count = error_count + int'(DUT.u_chk.assert_fails);
    end
    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_modbus_rtu_slave_chk.sv
// ==============================
// Port assertions bound into the slave top level
// tx_b_v is registered, so reset is checked from its second cycle
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_modbus_rtu_slave_chk (
  input logic clk,
  input logic rst,
  input logic tx_b_v,
  input logic tx_b_rdy,
  input logic stat_crc_err
);

  int unsigned assert_fails = 0;

  // A byte leaves only after ready was sampled high
  a_tx_after_rdy: assert property (@(posedge clk) disable iff (rst)
    tx_b_v |-> $past(tx_b_rdy))
    else begin
      $error("tx_b_v without tx_b_rdy in the previous cycle");
      assert_fails++;
    end

  a_tx_quiet_rst: assert property (@(posedge clk) rst && $past(rst) |-> !tx_b_v)
    else begin
      $error("tx_b_v high during reset");
      assert_fails++;
    end

  // Sticky error flag, only reset clears it
  a_crc_err_sticky: assert property (@(posedge clk)
    $past(stat_crc_err) && !$past(rst) |-> stat_crc_err)
    else begin
      $error("stat_crc_err fell without reset");
      assert_fails++;
    end

endmodule

bind modbus_rtu_slave tb_modbus_rtu_slave_chk u_chk (
  .clk(clk), .rst(rst), .tx_b_v(tx_b_v), .tx_b_rdy(tx_b_rdy), .stat_crc_err(stat_crc_err)
);

`default_nettype wire
